// ==== flist.f ====
+incdir+test
common/bridge_pkg.sv
common/av_pkg.sv
hdl/core_control.sv
video/video_conditioner.sv
audio/audio_clock_gen.sv
audio/i2s_serializer.sv
hdl/core_top.sv
test/tb_core_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core top level testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_core_top -f flist.f -o tb_core_top

# the simulator exits nonzero on a fatal check, the log decides
./obj_dir/tb_core_top > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
  exit 1
fi
if ! grep -q "Test passed" sim.log; then
  exit 1
fi
exit 0

// ==== test/tb_tasks.svh ====
// testbench tasks for the core top level
// value check, xorshift source, bridge read and write
// sample handshake, i2s capture and the directed tests

`ifndef tb_tasks_svh
`define tb_tasks_svh

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("error: %s got %h expected %h", name, got, exp);
      $display("Test failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] value);
    rng_state = xorshift32(rng_state);
    value     = rng_state;
  endtask

  // wr for exactly one cycle
  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    bridge.addr    <= addr;
    bridge.wr_data <= data;
    bridge.rd      <= 1'b0;
    bridge.wr      <= 1'b1;
    @(posedge clk_74a);
    bridge.wr <= 1'b0;
  endtask

  // data is taken one cycle after rd
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    bridge.addr <= addr;
    bridge.wr   <= 1'b0;
    bridge.rd   <= 1'b1;
    @(posedge clk_74a);
    bridge.rd <= 1'b0;
    @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  // four-phase req/ack, waits on each phase
  task automatic send_sample(input logic [av_pkg::sample_w-1:0] sample);
    @(negedge clk_74a);
    check_value("audio_ack idle", 32'(audio_ack), 32'd0);
    @(posedge clk_74a);
    audio_sample <= sample;
    audio_req    <= 1'b1;
    @(negedge clk_74a);
    while (!audio_ack) begin
      @(negedge clk_74a);
    end
    // ack holds while req stays up
    repeat (3) begin
      @(negedge clk_74a);
      check_value("audio_ack held", 32'(audio_ack), 32'd1);
    end
    @(posedge clk_74a);
    audio_req <= 1'b0;
    @(negedge clk_74a);
    while (audio_ack) begin
      @(negedge clk_74a);
    end
  endtask

  task automatic wait_sclk_rise();
    logic prev;
    prev = audio_sclk;
    @(negedge clk_74a);
    while (prev || !audio_sclk) begin
      prev = audio_sclk;
      @(negedge clk_74a);
    end
  endtask

  task automatic wait_lrck_rise();
    logic prev;
    prev = audio_lrck;
    @(negedge clk_74a);
    while (prev || !audio_lrck) begin
      prev = audio_lrck;
      @(negedge clk_74a);
    end
  endtask

  // one bit per sclk rise, dac is mid-bit there
  task automatic collect_i2s_bits();
    for (int i = 0; i < 49; i++) begin
      wait_sclk_rise();
      dac_log[i] = audio_dac;
      lr_log[i]  = audio_lrck;
    end
  endtask

  ////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////

  task automatic register_access();
    logic [31:0] rd;
    logic [31:0] addr;
    logic [31:0] both;
    logic [31:0] run_only;
    run_only = 32'd1 << bridge_pkg::run_bit;
    both     = run_only | (32'd1 << bridge_pkg::dl_bit);
    bridge_read(bridge_pkg::status_addr, rd);
    check_value("bridge_rd_data status after reset", rd, 32'd0);
    bridge_read(bridge_pkg::ctrl_addr, rd);
    check_value("bridge_rd_data ctrl after reset", rd, 32'd0);
    bridge_write(bridge_pkg::ctrl_addr, both);
    bridge_read(bridge_pkg::status_addr, rd);
    check_value("bridge_rd_data status run dl", rd, both);
    // no new rd, data holds while the address moves away
    @(posedge clk_74a);
    bridge.addr <= bridge_pkg::done_addr;
    repeat (3) @(posedge clk_74a);
    @(negedge clk_74a);
    check_value("bridge_rd_data held", bridge_rd_data, both);
    bridge_read(bridge_pkg::ctrl_addr, rd);
    check_value("bridge_rd_data ctrl run dl", rd, both);
    // done write ends the download, run stays
    next_rand(addr);
    bridge_write(bridge_pkg::done_addr, addr);
    bridge_read(bridge_pkg::status_addr, rd);
    check_value("bridge_rd_data status after done", rd, run_only);
    repeat (4) begin
      next_rand(addr);
      while (addr == bridge_pkg::ctrl_addr || addr == bridge_pkg::done_addr ||
             addr == bridge_pkg::status_addr) begin
        next_rand(addr);
      end
      bridge_write(addr, both);
      bridge_read(addr, rd);
      check_value("bridge_rd_data unmapped", rd, 32'd0);
      bridge_read(bridge_pkg::status_addr, rd);
      check_value("bridge_rd_data status unchanged", rd, run_only);
    end
  endtask

  task automatic video_gating();
    av_pkg::src_video_t cur;
    av_pkg::src_video_t prev;
    logic [31:0]        r;
    logic               exp_de;
    prev = '0;
    for (int i = 0; i < 64; i++) begin
      next_rand(r);
      cur        = '0;
      cur.rgb    = r[23:0];
      cur.hblank = r[24];
      cur.vblank = r[25];
      @(posedge clk_74a);
      src_video <= cur;
      @(negedge clk_74a);
      // output shows the pixel driven one edge before
      if (i > 0) begin
        exp_de = !(prev.hblank || prev.vblank);
        check_value("out_video.de", 32'(out_video.de), 32'(exp_de));
        check_value("out_video.rgb", 32'(out_video.rgb), exp_de ? 32'(prev.rgb) : 32'd0);
      end
      prev = cur;
    end
    // core halted, scaler sees nothing
    bridge_write(bridge_pkg::ctrl_addr, 32'd0);
    repeat (64) begin
      next_rand(r);
      @(posedge clk_74a);
      src_video <= av_pkg::src_video_t'(r[27:0]);
      @(negedge clk_74a);
      check_value("out_video halted", 32'(out_video), 32'd0);
    end
    bridge_write(bridge_pkg::ctrl_addr, 32'd1 << bridge_pkg::run_bit);
  endtask

  // vs pulse 1 cycle after the edge and hs pulse 7 cycles after it
  task automatic sync_case(input logic drive_hs, input logic drive_vs);
    av_pkg::src_video_t v;
    v        = '0;
    v.hblank = 1'b1;
    v.vblank = 1'b1;
    @(posedge clk_74a);
    src_video <= v;
    repeat (3) @(posedge clk_74a);
    v.hs = drive_hs;
    v.vs = drive_vs;
    src_video <= v;
    for (int k = 1; k <= 12; k++) begin
      @(posedge clk_74a);
      // drop the syncs, no second edge
      if (k == 3) begin
        v.hs = 1'b0;
        v.vs = 1'b0;
        src_video <= v;
      end
      @(negedge clk_74a);
      check_value("out_video.hs", 32'(out_video.hs), 32'(drive_hs && (k == 7)));
      check_value("out_video.vs", 32'(out_video.vs), 32'(drive_vs && (k == 1)));
    end
  endtask

  task automatic sync_pulses();
    sync_case(1'b1, 1'b0);
    sync_case(1'b0, 1'b1);
    sync_case(1'b1, 1'b1);
  endtask

  task automatic sample_handshake();
    logic [31:0] r;
    repeat (4) begin
      next_rand(r);
      send_sample(r[15:0]);
    end
  endtask

  task automatic i2s_output();
    logic [31:0] r;
    logic [15:0] exp_word;
    logic [15:0] left_bits;
    logic [15:0] pad_bits;
    logic [15:0] right_bits;
    logic [31:0] lr_high;
    logic [16:0] lr_low;
    repeat (3) begin
      next_rand(r);
      // leading zero, then sample bits 15 to 1
      exp_word = {1'b0, r[15:1]};
      send_sample(r[15:0]);
      wait_lrck_rise();
      collect_i2s_bits();
      // skip the bit at the lrck edge, then msb first
      for (int i = 0; i < 16; i++) begin
        left_bits  = {left_bits[14:0], dac_log[1 + i]};
        pad_bits   = {pad_bits[14:0], dac_log[17 + i]};
        right_bits = {right_bits[14:0], dac_log[33 + i]};
      end
      for (int i = 0; i < 32; i++) begin
        lr_high = {lr_high[30:0], lr_log[i]};
      end
      for (int i = 0; i < 17; i++) begin
        lr_low = {lr_low[15:0], lr_log[32 + i]};
      end
      check_value("audio_lrck left slot", lr_high, 32'hffff_ffff);
      check_value("audio_lrck right slot", 32'(lr_low), 32'd0);
      check_value("audio_dac left", 32'(left_bits), 32'(exp_word));
      check_value("audio_dac left pad", 32'(pad_bits), 32'd0);
      check_value("audio_dac right", 32'(right_bits), 32'(exp_word));
    end
  endtask

  // mclk toggle count over a window, then four mclk rises per sclk period
  task automatic clock_rates();
    logic        prev_mclk;
    logic        prev_sclk;
    logic        sclk_rose;
    logic [31:0] toggles;
    logic [31:0] rises;
    logic [31:0] lo;
    // whole toggles in 1000 cycles, phase adds at most one more
    lo        = 32'((64'd1000 * av_pkg::mclk_step) / av_pkg::mclk_wrap);
    toggles   = '0;
    prev_mclk = audio_mclk;
    repeat (1000) begin
      @(negedge clk_74a);
      if (audio_mclk != prev_mclk) begin
        toggles = toggles + 32'd1;
      end
      prev_mclk = audio_mclk;
    end
    check_value("audio_mclk toggles", toggles, (toggles == lo + 32'd1) ? lo + 32'd1 : lo);
    wait_sclk_rise();
    repeat (4) begin
      rises     = '0;
      prev_mclk = audio_mclk;
      prev_sclk = audio_sclk;
      do begin
        @(negedge clk_74a);
        if (!prev_mclk && audio_mclk) begin
          rises = rises + 32'd1;
        end
        sclk_rose = !prev_sclk && audio_sclk;
        prev_mclk = audio_mclk;
        prev_sclk = audio_sclk;
      end while (!sclk_rose);
      check_value("audio_sclk mclk rises per period", rises, 32'd4);
    end
  endtask

`endif

// ==== test/tb_core_top.sv ====
// testbench for the core top level
// clock, reset, DUT instance and run timeout
// directed test sequence, tasks come from the included header

`timescale 1ns/10ps
`default_nettype none

module tb_core_top;

  // an i2s frame is about 1550 clocks, each i2s sample check spans up to two
  // frames, three samples plus the short tests stay well under this
  localparam int timeout_cycles = 20000;

  logic                        clk_74a;
  logic                        rst;

  // DUT ports
  bridge_pkg::bridge_req_t     bridge;
  logic [31:0]                 bridge_rd_data;
  av_pkg::src_video_t          src_video;
  av_pkg::out_video_t          out_video;
  logic                        audio_req;
  logic [av_pkg::sample_w-1:0] audio_sample;
  logic                        audio_ack;
  logic                        audio_mclk;
  logic                        audio_sclk;
  logic                        audio_dac;
  logic                        audio_lrck;

  // xorshift state
  logic [31:0]                 rng_state;
  int                          cycle_cnt = 0;

  // dac and lrck seen at each sclk rise
  logic                        dac_log [0:48];
  logic                        lr_log  [0:48];

  core_top core_top_i (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge         (bridge),
    .bridge_rd_data (bridge_rd_data),
    .src_video      (src_video),
    .out_video      (out_video),
    .audio_req      (audio_req),
    .audio_sample   (audio_sample),
    .audio_ack      (audio_ack),
    .audio_mclk     (audio_mclk),
    .audio_sclk     (audio_sclk),
    .audio_dac      (audio_dac),
    .audio_lrck     (audio_lrck)
  );

  // 10 ns clock
  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  // cycle limit, ends a run that stalls on a handshake or edge
  always @(posedge clk_74a) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("timeout: no result after %0d clock cycles", timeout_cycles);
      $display("Test failed");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    rst          = 1'b1;
    bridge       = '0;
    src_video    = '0;
    audio_req    = 1'b0;
    audio_sample = '0;
    rng_state    = 32'ha69fbed0;
    // reset held over 4 rising edges
    repeat (4) @(posedge clk_74a);
    rst <= 1'b0;
    @(posedge clk_74a);

    register_access();
    video_gating();
    sync_pulses();
    sample_handshake();
    i2s_output();
    clock_rates();

    repeat (4) @(posedge clk_74a);
    $display("Test passed");
    $finish;
  end

  `include "tb_tasks.svh"

endmodule

`default_nettype wire

// ==== hdl/core_top.sv ====
// core top level
// bridge register block, video conditioner
// audio clock generator and i2s serializer

`timescale 1ns/10ps
`default_nettype none

module core_top (
  input  wire                          clk_74a,
  input  wire                          rst,

  // host bridge
  input  wire bridge_pkg::bridge_req_t bridge,
  output logic [31:0]                  bridge_rd_data,

  // video in from the core, out to the scaler
  input  wire av_pkg::src_video_t      src_video,
  output av_pkg::out_video_t           out_video,

  // sample intake, four-phase req/ack
  input  wire                          audio_req,
  input  wire [av_pkg::sample_w-1:0]   audio_sample,
  output logic                         audio_ack,

  // i2s pins
  output logic                         audio_mclk,
  output logic                         audio_sclk,
  output logic                         audio_dac,
  output logic                         audio_lrck
);

  // run flag fans out to video and audio
  logic run;
  // one strobe per i2s bit time
  logic sclk_fall;

  ////////////////////////////////////////
  // control
  ////////////////////////////////////////

  // downloading is only seen through the status register here
  core_control core_control_i (
    .clk_74a        (clk_74a),
    .rst            (rst),
    .bridge         (bridge),
    .bridge_rd_data (bridge_rd_data),
    .run            (run),
    .downloading    ()
  );

  ////////////////////////////////////////
  // video
  ////////////////////////////////////////

  video_conditioner video_conditioner_i (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .run       (run),
    .src_video (src_video),
    .out_video (out_video)
  );

  ////////////////////////////////////////
  // audio
  ////////////////////////////////////////

  audio_clock_gen audio_clock_gen_i (
    .clk_74a   (clk_74a),
    .rst       (rst),
    .mclk      (audio_mclk),
    .sclk      (audio_sclk),
    .sclk_fall (sclk_fall)
  );

  i2s_serializer i2s_serializer_i (
    .clk_74a      (clk_74a),
    .rst          (rst),
    .run          (run),
    .sclk_fall    (sclk_fall),
    .audio_req    (audio_req),
    .audio_sample (audio_sample),
    .audio_ack    (audio_ack),
    .dac          (audio_dac),
    .lrck         (audio_lrck)
  );

endmodule

`default_nettype wire

// ==== audio/i2s_serializer.sv ====
// i2s serializer
// four-phase sample intake with pending sample register
// 16 active bits per 32-bit channel slot, msb first

`timescale 1ns/10ps
`default_nettype none

module i2s_serializer (
  input  wire                        clk_74a,
  input  wire                        rst,
  input  wire                        run,
  input  wire                        sclk_fall,
  input  wire                        audio_req,
  input  wire [av_pkg::sample_w-1:0] audio_sample,
  output logic                       audio_ack,
  output logic                       dac,
  output logic                       lrck
);

  // last sample taken from the source
  logic [av_pkg::sample_w-1:0]  pending;
  // same word for both channels
  logic [av_pkg::slot_bits-1:0] fmt_word;
  logic [av_pkg::slot_bits-1:0] shift;
  // bit position inside the channel slot
  logic [4:0]                   slot_cnt;

  ////////////////////////////////////////
  // sample intake
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      audio_ack <= 1'b0;
    end else if (audio_req && !audio_ack) begin
      audio_ack <= 1'b1;
    end else if (!audio_req) begin
      audio_ack <= 1'b0;
    end
  end

  // newer sample overwrites, no back-pressure
  always_ff @(posedge clk_74a) begin
    if (audio_req && !audio_ack) begin
      pending <= audio_sample;
    end
  end

  // leading zero then the top 15 bits, halved to stay in range
  assign fmt_word = {1'b0, pending[av_pkg::sample_w-1:1], 1'b0, pending[av_pkg::sample_w-1:1]};

  ////////////////////////////////////////
  // shift out
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      dac      <= 1'b0;
      lrck     <= 1'b0;
      slot_cnt <= '0;
      shift    <= '0;
    end else if (sclk_fall) begin
      dac      <= run ? shift[av_pkg::slot_bits-1] : 1'b0;
      slot_cnt <= slot_cnt + 5'd1;
      if (slot_cnt == 5'(av_pkg::slot_bits - 1)) begin
        // end of slot, switch channel
        lrck <= ~lrck;
        // load only when going to the left channel
        if (!lrck && run) begin
          shift <= fmt_word;
        end
      end else if (!run) begin
        shift <= '0;
      end else if (slot_cnt < 5'(av_pkg::sample_w)) begin
        // first 16 bit times only
        shift <= {shift[av_pkg::slot_bits-2:0], 1'b0};
      end
    end
  end

  // ack answers a held request, never runs ahead of it
  a_ack_follows_req : assert property (
    @(posedge clk_74a) disable iff (rst)
    $rose(audio_ack) |-> $past(audio_req)
  );

endmodule

`default_nettype wire

// ==== audio/audio_clock_gen.sv ====
// audio clock generator
// fractional accumulator for mclk
// sclk as mclk divided by four, with falling-edge strobe

`timescale 1ns/10ps
`default_nettype none

module audio_clock_gen (
  input  wire  clk_74a,
  input  wire  rst,
  output logic mclk,
  output logic sclk,
  output logic sclk_fall
);

  // phase accumulator, toggles mclk on wrap
  logic [21:0] accum;
  // mclk divider, msb is sclk
  logic [1:0]  div;
  logic        wrap_hit;

  assign wrap_hit = (accum >= av_pkg::mclk_wrap);
  assign sclk     = div[1];

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      accum     <= '0;
      mclk      <= 1'b0;
      div       <= '0;
      sclk_fall <= 1'b0;
    end else begin
      sclk_fall <= 1'b0;
      if (wrap_hit) begin
        accum <= accum - av_pkg::mclk_wrap + av_pkg::mclk_step;
        mclk  <= ~mclk;
        // mclk about to rise, step the divider
        if (!mclk) begin
          div       <= div + 2'd1;
          // 3 -> 0 drops sclk
          sclk_fall <= (div == 2'b11);
        end
      end else begin
        accum <= accum + av_pkg::mclk_step;
      end
    end
  end

  // wrap is checked every cycle so the excess never exceeds one step
  a_accum_bound : assert property (
    @(posedge clk_74a) disable iff (rst)
    accum < (av_pkg::mclk_wrap + av_pkg::mclk_step)
  );

endmodule

`default_nettype wire

// ==== video/video_conditioner.sv ====
// video output conditioner
// data enable from blanking, rgb blanked outside active area
// delayed hs pulse and single-cycle vs pulse

`timescale 1ns/10ps
`default_nettype none

module video_conditioner (
  input  wire                     clk_74a,
  input  wire                     rst,
  input  wire                     run,
  input  wire av_pkg::src_video_t src_video,
  output av_pkg::out_video_t      out_video
);

  // previous sync levels for edge detect
  logic       hs_prev;
  logic       vs_prev;
  // counts down to the hs pulse
  logic [2:0] hs_cnt;

  logic       hs_rise;
  logic       vs_rise;
  logic       active;

  assign hs_rise = src_video.hs && !hs_prev;
  assign vs_rise = src_video.vs && !vs_prev;
  assign active  = !(src_video.hblank || src_video.vblank);

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      out_video <= '0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
      hs_cnt    <= '0;
    end else begin
      hs_prev <= src_video.hs;
      vs_prev <= src_video.vs;
      if (!run) begin
        // core halted, hold the scaler quiet
        out_video <= '0;
        hs_cnt    <= '0;
      end else begin
        out_video.de  <= active;
        out_video.rgb <= active ? src_video.rgb : 24'h0;
        // vs out the cycle after its edge
        out_video.vs  <= vs_rise;
        // count of 2 fires hs, lands 7 cycles after the edge
        out_video.hs  <= (hs_cnt == 3'd2);
        if (hs_rise) begin
          hs_cnt <= av_pkg::hs_delay;
        end else if (hs_cnt != 3'd0) begin
          hs_cnt <= hs_cnt - 3'd1;
        end
      end
    end
  end

  // delay keeps the scaler from seeing both syncs at once
  a_hs_vs_apart : assert property (
    @(posedge clk_74a) disable iff (rst)
    !(out_video.hs && out_video.vs)
  );

endmodule

`default_nettype wire

// ==== hdl/core_control.sv ====
// bridge register block
// run and downloading flags
// registered read mux, zero for unmapped addresses

`timescale 1ns/10ps
`default_nettype none

module core_control (
  input  wire                          clk_74a,
  input  wire                          rst,
  input  wire bridge_pkg::bridge_req_t bridge,
  output logic [31:0]                  bridge_rd_data,
  output logic                         run,
  output logic                         downloading
);

  // address decode
  logic        hit_ctrl;
  logic        hit_done;
  logic        hit_status;

  // flags packed at their bit positions
  logic [31:0] status_word;
  // read data before the output register
  logic [31:0] rd_mux;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  assign hit_ctrl   = (bridge.addr == bridge_pkg::ctrl_addr);
  assign hit_done   = (bridge.addr == bridge_pkg::done_addr);
  assign hit_status = (bridge.addr == bridge_pkg::status_addr);

  always_comb begin
    status_word = '0;
    status_word[bridge_pkg::run_bit] = run;
    status_word[bridge_pkg::dl_bit]  = downloading;
  end

  // ctrl reads back the same word as status
  always_comb begin
    if (hit_ctrl || hit_status) begin
      rd_mux = status_word;
    end else begin
      rd_mux = '0;
    end
  end

  ////////////////////////////////////////
  // flags
  ////////////////////////////////////////

  always_ff @(posedge clk_74a) begin
    if (rst) begin
      run         <= 1'b0;
      downloading <= 1'b0;
    end else if (bridge.wr) begin
      if (hit_ctrl) begin
        // run follows the written bit
        run <= bridge.wr_data[bridge_pkg::run_bit];
        // dl only sets here, cleared by done
        if (bridge.wr_data[bridge_pkg::dl_bit]) begin
          downloading <= 1'b1;
        end
      end else if (hit_done) begin
        downloading <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // read data
  ////////////////////////////////////////

  // one cycle latency, held until the next rd
  always_ff @(posedge clk_74a) begin
    if (rst) begin
      bridge_rd_data <= '0;
    end else if (bridge.rd) begin
      bridge_rd_data <= rd_mux;
    end
  end

  // host issues one access per cycle
  a_rd_wr_exclusive : assert property (
    @(posedge clk_74a) disable iff (rst)
    !(bridge.rd && bridge.wr)
  );

endmodule

`default_nettype wire

// ==== common/av_pkg.sv ====
// audio and video definitions
// source and output video structs
// i2s clocking and slot format constants

`default_nettype none

package av_pkg;

  ////////////////////////////////////////
  // video
  ////////////////////////////////////////

  // pixel and sync as they leave the emulator core
  typedef struct packed {
    logic [23:0] rgb;
    logic        hblank;
    logic        vblank;
    logic        hs;
    logic        vs;
  } src_video_t;

  // conditioned video for the scaler
  typedef struct packed {
    logic [23:0] rgb;
    logic        de;
    logic        hs;
    logic        vs;
  } out_video_t;

  // hs pulse lag after the source edge, keeps it clear of vs
  localparam logic [2:0] hs_delay = 3'd7;

  ////////////////////////////////////////
  // audio
  ////////////////////////////////////////

  // mclk = 74.25 mhz * step / (2 * wrap), about 12.288 mhz
  localparam logic [21:0] mclk_step = 22'd245760;
  localparam logic [21:0] mclk_wrap = 22'd742500;

  // active bits per channel and bits per channel slot
  localparam int sample_w  = 16;
  localparam int slot_bits = 32;

endpackage

`default_nettype wire

// ==== common/bridge_pkg.sv ====
// host bridge definitions
// bus cycle struct for one bridge access
// register address map and control/status bit positions

`default_nettype none

package bridge_pkg;

  ////////////////////////////////////////
  // bus cycle
  ////////////////////////////////////////

  // one host access, rd and wr are single-cycle strobes
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  ////////////////////////////////////////
  // address map
  ////////////////////////////////////////

  // control register, read back as status
  localparam logic [31:0] ctrl_addr   = 32'hF800_0000;
  // any write here ends a download
  localparam logic [31:0] done_addr   = 32'hF800_0004;
  // read-only status
  localparam logic [31:0] status_addr = 32'hF800_0008;

  // bit positions in control and status words
  localparam logic [4:0] run_bit = 5'd0;
  localparam logic [4:0] dl_bit  = 5'd1;

endpackage

`default_nettype wire
